// ==== compile.f ====
+incdir+verif
src/PECfg.sv
src/PECtlCfg.sv
src/LoopCounter.sv
src/ScratchPad.sv
src/DataPathController.sv
src/MacUnit.sv
src/ProcessingElement.sv
verif/ProcessingElementTb.sv

// ==== src/DataPathController.sv ====
module DataPathController #(
    parameter int IN_DEPTH = PECfg::IN_DEPTH,
    parameter int W_DEPTH  = PECfg::W_DEPTH
) (
    input  logic             i_clk,
    input  logic             i_arstN,
    // run control
    input  logic             i_start,
    input  logic             i_stall,
    // configuration
    input  PECfg::tConfPch   i_confPch,
    input  PECfg::tConfR     i_confR,
    input  PECfg::tConfPm    i_confPm,
    input  PECfg::tConfTw    i_confTw,
    // load streams
    input  logic             i_inRdy,
    input  logic             i_wRdy,
    output logic             o_inAck,
    output logic             o_wAck,
    // pad fill
    input  logic             i_inFull,
    input  logic             i_wFull,
    output logic             o_padClear,
    output logic [6:0]       o_inFill,
    output logic [6:0]       o_wFill,
    // pad read
    output PECtlCfg::tInAddr o_inAddr,
    output PECtlCfg::tWAddr  o_wAddr,
    output logic             o_rdEn,
    // MAC control
    output logic             o_sumFirst,
    output logic             o_sumLast,
    output logic             o_macEn,
    input  logic             i_bufBusy,
    // status
    output logic             o_busy
);

    localparam int LoopW = 4;

    PECtlCfg::tRunState state;
    PECtlCfg::tRunState stateNxt;

    logic [LoopW-1:0] loopBound [4];
    logic [LoopW-1:0] loopIdx [4];
    logic [3:0]       loopEnd;
    logic [LoopW-1:0] idxR;
    logic [LoopW-1:0] idxCh;
    logic [LoopW-1:0] idxM;
    logic [LoopW-1:0] idxW;

    logic [6:0] inRow;
    logic [6:0] inFillRaw;
    logic [6:0] wFillRaw;
    logic [6:0] inAddrFull;
    logic [6:0] wAddrFull;

    logic adv;
    logic issue;
    logic sumStart;
    logic sumEnd;
    logic runEnd;
    // read stage flags, aligned with the pad read data
    logic valid1;
    logic first1;
    logic last1;

    // ==================================================================
    // fill counts and addresses
    // ==================================================================
    assign inRow     = 7'(i_confTw) + 7'(i_confR) - 7'd1;
    assign inFillRaw = 7'(i_confPch) * inRow;
    assign wFillRaw  = 7'(i_confPm) * 7'(i_confPch) * 7'(i_confR);

    // out-of-range configs are clipped to the pad size
    assign o_inFill = (inFillRaw > 7'(IN_DEPTH)) ? 7'(IN_DEPTH) : inFillRaw;
    assign o_wFill  = (wFillRaw > 7'(W_DEPTH)) ? 7'(W_DEPTH) : wFillRaw;

    // r innermost, then ch, m and output column w
    assign loopBound[0] = LoopW'(i_confR);
    assign loopBound[1] = LoopW'(i_confPch);
    assign loopBound[2] = LoopW'(i_confPm);
    assign loopBound[3] = LoopW'(i_confTw);

    assign idxR  = loopIdx[0];
    assign idxCh = loopIdx[1];
    assign idxM  = loopIdx[2];
    assign idxW  = loopIdx[3];

    assign inAddrFull = 7'(idxCh) * inRow + 7'(idxW) + 7'(idxR);
    assign wAddrFull  = (7'(idxM) * 7'(i_confPch) + 7'(idxCh)) * 7'(i_confR) + 7'(idxR);
    assign o_inAddr   = PECtlCfg::tInAddr'(inAddrFull);
    assign o_wAddr    = PECtlCfg::tWAddr'(wAddrFull);

    assign sumStart = (idxR == '0) && (idxCh == '0);
    assign sumEnd   = loopEnd[0] & loopEnd[1];
    assign runEnd   = &loopEnd;

    LoopCounter #(
        .NDepth(4),
        .IdxW  (LoopW)
    ) loop0 (
        .i_clk  (i_clk),
        .i_arstN(i_arstN),
        .i_clear(o_padClear),
        .i_step (issue),
        .i_bound(loopBound),
        .o_idx  (loopIdx),
        .o_end  (loopEnd)
    );

    // ==================================================================
    // run state machine
    // ==================================================================
    always_comb begin
        stateNxt = state;
        case (state)
            PECtlCfg::IDLE: begin
                if (i_start) begin
                    stateNxt = PECtlCfg::LOAD;
                end
            end
            PECtlCfg::LOAD: begin
                if (i_inFull && i_wFull) begin
                    stateNxt = PECtlCfg::WORK;
                end
            end
            PECtlCfg::WORK: begin
                if (i_stall) begin
                    stateNxt = PECtlCfg::STALL;
                end else if (issue && runEnd) begin
                    stateNxt = PECtlCfg::DRAIN;
                end
            end
            PECtlCfg::STALL: begin
                if (!i_stall) begin
                    stateNxt = PECtlCfg::WORK;
                end
            end
            PECtlCfg::DRAIN: begin
                // last sum has reached the buffer and been taken
                if (!valid1 && !i_bufBusy) begin
                    stateNxt = PECtlCfg::IDLE;
                end
            end
            default: begin
                stateNxt = PECtlCfg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state <= PECtlCfg::IDLE;
        end else begin
            state <= stateNxt;
        end
    end

    // a new sum waits for the output buffer, else the sum ahead of it is lost
    always_comb begin
        case (state)
            PECtlCfg::WORK:  adv = !i_stall && !(sumStart && i_bufBusy);
            PECtlCfg::DRAIN: adv = !i_bufBusy;
            default:         adv = 1'b0;
        endcase
    end

    assign issue      = (state == PECtlCfg::WORK) && adv;
    assign o_padClear = (state == PECtlCfg::IDLE) && i_start;
    assign o_inAck    = (state == PECtlCfg::LOAD) && !i_inFull && i_inRdy;
    assign o_wAck     = (state == PECtlCfg::LOAD) && !i_wFull && i_wRdy;
    assign o_busy     = (state != PECtlCfg::IDLE);

    // ==================================================================
    // read stage flags
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            valid1 <= 1'b0;
            first1 <= 1'b0;
            last1  <= 1'b0;
        end else if (o_padClear) begin
            valid1 <= 1'b0;
            first1 <= 1'b0;
            last1  <= 1'b0;
        end else if (adv) begin
            valid1 <= issue;
            first1 <= sumStart;
            last1  <= sumEnd;
        end
    end

    assign o_rdEn     = issue;
    assign o_macEn    = adv && valid1;
    assign o_sumFirst = first1;
    assign o_sumLast  = last1;

endmodule

// ==== src/LoopCounter.sv ====
module LoopCounter #(
    parameter int NDepth = 4,
    parameter int IdxW   = 4
) (
    input  logic              i_clk,
    input  logic              i_arstN,
    input  logic              i_clear,
    input  logic              i_step,
    input  logic [IdxW-1:0]   i_bound [NDepth],
    output logic [IdxW-1:0]   o_idx [NDepth],
    output logic [NDepth-1:0] o_end
);

    // level i may move only when every inner level wraps
    logic [NDepth-1:0] carry;

    // ==================================================================
    // end flags and carry chain
    // ==================================================================
    always_comb begin
        for (int i = 0; i < NDepth; i++) begin
            o_end[i] = (o_idx[i] == i_bound[i] - 1'b1);
        end
    end

    always_comb begin
        carry[0] = 1'b1;
        for (int i = 1; i < NDepth; i++) begin
            carry[i] = carry[i-1] & o_end[i-1];
        end
    end

    // ==================================================================
    // index registers
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < NDepth; i++) begin
                o_idx[i] <= '0;
            end
        end else if (i_clear) begin
            for (int i = 0; i < NDepth; i++) begin
                o_idx[i] <= '0;
            end
        end else if (i_step) begin
            for (int i = 0; i < NDepth; i++) begin
                if (carry[i]) begin
                    // wrap at bound - 1, otherwise count up
                    if (o_end[i]) begin
                        o_idx[i] <= '0;
                    end else begin
                        o_idx[i] <= o_idx[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== src/MacUnit.sv ====
module MacUnit (
    input  logic          i_clk,
    input  logic          i_arstN,
    // product stream from the pads
    input  logic          i_en,
    input  logic          i_first,
    input  logic          i_last,
    input  PECfg::tPixel  i_pixel,
    input  PECfg::tWeight i_weight,
    // output buffer and psum stream
    output logic          o_bufBusy,
    output logic          o_psumRdy,
    output PECfg::tPsum   o_psumData,
    input  logic          i_psumAck
);

    PECfg::tPsum product;
    PECfg::tPsum acc;
    PECfg::tPsum sumNxt;

    // ==================================================================
    // multiply and accumulate
    // ==================================================================
    // operands widen to the psum width before the multiply
    assign product = i_pixel * i_weight;

    // first product of a sum starts from zero
    assign sumNxt = (i_first ? PECfg::tPsum'(0) : acc) + product;

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            acc <= sumNxt;
        end
    end

    // ==================================================================
    // one-entry output buffer
    // ==================================================================
    // value stays put until the sink acks it
    always_ff @(posedge i_clk) begin
        if (i_en && i_last) begin
            o_psumData <= sumNxt;
        end
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_psumRdy <= 1'b0;
        end else if (i_en && i_last) begin
            o_psumRdy <= 1'b1;
        end else if (i_psumAck) begin
            o_psumRdy <= 1'b0;
        end
    end

    // controller holds the next sum while this is high
    assign o_bufBusy = o_psumRdy;

endmodule

// ==== src/PECfg.sv ====
package PECfg;

    // ==================================================================
    // data words
    // ==================================================================
    // input pixel and filter weight, both signed
    typedef logic signed [7:0]  tPixel;
    typedef logic signed [7:0]  tWeight;

    // wide enough for MAX_PCH * MAX_R full-scale products
    typedef logic signed [23:0] tPsum;

    // ==================================================================
    // run configuration limits
    // ==================================================================
    localparam int MAX_PCH = 4;
    localparam int MAX_R   = 4;
    localparam int MAX_PM  = 4;
    localparam int MAX_TW  = 8;

    // each field runs from 1 up to its limit
    typedef logic [2:0] tConfPch;
    typedef logic [2:0] tConfR;
    typedef logic [2:0] tConfPm;
    typedef logic [3:0] tConfTw;

    // ==================================================================
    // scratchpad sizing
    // ==================================================================
    // one full input row per channel
    localparam int IN_DEPTH = MAX_PCH * (MAX_TW + MAX_R - 1);
    // every filter, channel and tap
    localparam int W_DEPTH  = MAX_PM * MAX_PCH * MAX_R;

endpackage

// ==== src/PECtlCfg.sv ====
package PECtlCfg;

    // ==================================================================
    // run state machine
    // ==================================================================
    // IDLE   waits for the start pulse
    // LOAD   fills both pads from the load streams
    // WORK   issues one address pair per cycle
    // STALL  holds address issue and the read pipeline
    // DRAIN  flushes the pipeline and waits for the last ack
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        WORK,
        STALL,
        DRAIN
    } tRunState;

    // ==================================================================
    // pad addresses
    // ==================================================================
    // input pad holds up to 44 pixels
    typedef logic [5:0] tInAddr;

    // weight pad holds up to 64 weights
    typedef logic [5:0] tWAddr;

endpackage

// ==== src/ProcessingElement.sv ====
module ProcessingElement #(
    parameter int IN_DEPTH = PECfg::IN_DEPTH,
    parameter int W_DEPTH  = PECfg::W_DEPTH
) (
    input  logic            i_clk,
    input  logic            i_arstN,
    // run control
    input  logic            i_start,
    input  logic            i_stall,
    // configuration
    input  PECfg::tConfPch  i_confPch,
    input  PECfg::tConfR    i_confR,
    input  PECfg::tConfPm   i_confPm,
    input  PECfg::tConfTw   i_confTw,
    // input pixel stream
    input  logic            i_inRdy,
    input  PECfg::tPixel    i_inData,
    output logic            o_inAck,
    // weight stream
    input  logic            i_wRdy,
    input  PECfg::tWeight   i_wData,
    output logic            o_wAck,
    // psum stream
    output logic            o_psumRdy,
    output PECfg::tPsum     o_psumData,
    input  logic            i_psumAck,
    output logic            o_busy
);

    logic             inFull;
    logic             wFull;
    logic             padClear;
    logic [6:0]       inFill;
    logic [6:0]       wFill;
    PECtlCfg::tInAddr inAddr;
    PECtlCfg::tWAddr  wAddr;
    logic             rdEn;
    logic             sumFirst;
    logic             sumLast;
    logic             macEn;
    logic             bufBusy;
    PECfg::tPixel     pixel;
    PECfg::tWeight    weight;

    DataPathController #(
        .IN_DEPTH(IN_DEPTH),
        .W_DEPTH (W_DEPTH)
    ) ctl0 (
        .i_clk     (i_clk),
        .i_arstN   (i_arstN),
        .i_start   (i_start),
        .i_stall   (i_stall),
        .i_confPch (i_confPch),
        .i_confR   (i_confR),
        .i_confPm  (i_confPm),
        .i_confTw  (i_confTw),
        .i_inRdy   (i_inRdy),
        .i_wRdy    (i_wRdy),
        .o_inAck   (o_inAck),
        .o_wAck    (o_wAck),
        .i_inFull  (inFull),
        .i_wFull   (wFull),
        .o_padClear(padClear),
        .o_inFill  (inFill),
        .o_wFill   (wFill),
        .o_inAddr  (inAddr),
        .o_wAddr   (wAddr),
        .o_rdEn    (rdEn),
        .o_sumFirst(sumFirst),
        .o_sumLast (sumLast),
        .o_macEn   (macEn),
        .i_bufBusy (bufBusy),
        .o_busy    (o_busy)
    );

    // ack is only raised while rdy is high, so ack alone marks a transfer
    ScratchPad #(
        .tEntry(PECfg::tPixel),
        .DEPTH (IN_DEPTH),
        .AddrW ($bits(PECtlCfg::tInAddr))
    ) inPad0 (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_clear    (padClear),
        .i_wrEn     (o_inAck),
        .i_wrData   (i_inData),
        .i_fillCount(inFill),
        .o_full     (inFull),
        .i_rdEn     (rdEn),
        .i_rdAddr   (inAddr),
        .o_rdData   (pixel)
    );

    ScratchPad #(
        .tEntry(PECfg::tWeight),
        .DEPTH (W_DEPTH),
        .AddrW ($bits(PECtlCfg::tWAddr))
    ) wPad0 (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_clear    (padClear),
        .i_wrEn     (o_wAck),
        .i_wrData   (i_wData),
        .i_fillCount(wFill),
        .o_full     (wFull),
        .i_rdEn     (rdEn),
        .i_rdAddr   (wAddr),
        .o_rdData   (weight)
    );

    MacUnit mac0 (
        .i_clk     (i_clk),
        .i_arstN   (i_arstN),
        .i_en      (macEn),
        .i_first   (sumFirst),
        .i_last    (sumLast),
        .i_pixel   (pixel),
        .i_weight  (weight),
        .o_bufBusy (bufBusy),
        .o_psumRdy (o_psumRdy),
        .o_psumData(o_psumData),
        .i_psumAck (i_psumAck)
    );

endmodule

// ==== src/ScratchPad.sv ====
module ScratchPad #(
    parameter type tEntry = logic [7:0],
    parameter int  DEPTH  = 16,
    parameter int  AddrW  = 4
) (
    input  logic             i_clk,
    input  logic             i_arstN,
    input  logic             i_clear,
    // sequential fill
    input  logic             i_wrEn,
    input  tEntry            i_wrData,
    input  logic [AddrW:0]   i_fillCount,
    output logic             o_full,
    // registered read
    input  logic             i_rdEn,
    input  logic [AddrW-1:0] i_rdAddr,
    output tEntry            o_rdData
);

    tEntry          mem [DEPTH];
    // one bit wider than the address so a full pad is reachable
    logic [AddrW:0] wrPtr;

    assign o_full = (wrPtr == i_fillCount);

    // ==================================================================
    // write side
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            wrPtr <= '0;
        end else if (i_clear) begin
            wrPtr <= '0;
        end else if (i_wrEn && !o_full) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wrEn && !o_full) begin
            mem[wrPtr[AddrW-1:0]] <= i_wrData;
        end
    end

    // ==================================================================
    // read side
    // ==================================================================
    // data holds while i_rdEn is low, which freezes the pipeline
    always_ff @(posedge i_clk) begin
        if (i_rdEn) begin
            o_rdData <= mem[i_rdAddr];
        end
    end

endmodule

// ==== verif/peTestTable.svh ====
`ifndef PE_TEST_TABLE_SVH
`define PE_TEST_TABLE_SVH

// one run per row
// pch, r, pm, tw  run configuration
// stallOn         random i_stall pulses while the run is busy
// ackGapPct       chance in percent that i_psumAck is low in a cycle
// srcGapPct       chance in percent of an idle cycle before a load word
typedef struct packed {
    int pch;
    int r;
    int pm;
    int tw;
    bit stallOn;
    int ackGapPct;
    int srcGapPct;
} tTestRow;

localparam int NUM_ROWS = 8;

// the aborted run goes in front of this row, with its config
localparam int ABORT_ROW = 4;

localparam tTestRow TEST_ROWS [NUM_ROWS] = '{
    // pch r  pm tw stall  ack src
    '{1,  1, 1, 1, 1'b0,  0,  0},   // single product
    '{2,  3, 2, 4, 1'b0,  0,  0},
    '{3,  2, 3, 5, 1'b1,  0,  0},   // stalls only
    '{2,  2, 4, 6, 1'b0, 40,  0},   // psum back-pressure
    '{4,  3, 2, 8, 1'b0,  0, 40},   // load stream gaps
    '{4,  4, 4, 8, 1'b1, 30, 30},   // every pad entry used
    '{1,  4, 3, 8, 1'b1, 50, 20},
    '{2,  1, 4, 3, 1'b0, 50,  0}
};

`endif

// ==== verif/ProcessingElementTb.sv ====
module ProcessingElementTb;

    `include "peTestTable.svh"

    localparam int IN_ROW_MAX = PECfg::MAX_TW + PECfg::MAX_R - 1;

    logic           i_clk;
    logic           i_arstN;
    logic           i_start;
    logic           i_stall;
    PECfg::tConfPch i_confPch;
    PECfg::tConfR   i_confR;
    PECfg::tConfPm  i_confPm;
    PECfg::tConfTw  i_confTw;
    logic           i_inRdy;
    PECfg::tPixel   i_inData;
    logic           o_inAck;
    logic           i_wRdy;
    PECfg::tWeight  i_wData;
    logic           o_wAck;
    logic           o_psumRdy;
    PECfg::tPsum    o_psumData;
    logic           i_psumAck;
    logic           o_busy;

    // reference data of the current row
    PECfg::tPixel  pixMem [PECfg::MAX_PCH][IN_ROW_MAX];
    PECfg::tWeight wtMem [PECfg::MAX_PM][PECfg::MAX_PCH][PECfg::MAX_R];
    PECfg::tPsum   expQ [$];

    logic [31:0] rngState;
    logic        runDone;
    int          valueErrors  = 0;
    int          protoErrors  = 0;
    int          psumsChecked = 0;
    int          inXfers      = 0;
    int          wXfers       = 0;
    int          cycleCount   = 0;
    int          cycleLimit   = 0;

    ProcessingElement dut0 (
        .i_clk     (i_clk),
        .i_arstN   (i_arstN),
        .i_start   (i_start),
        .i_stall   (i_stall),
        .i_confPch (i_confPch),
        .i_confR   (i_confR),
        .i_confPm  (i_confPm),
        .i_confTw  (i_confTw),
        .i_inRdy   (i_inRdy),
        .i_inData  (i_inData),
        .o_inAck   (o_inAck),
        .i_wRdy    (i_wRdy),
        .i_wData   (i_wData),
        .o_wAck    (o_wAck),
        .o_psumRdy (o_psumRdy),
        .o_psumData(o_psumData),
        .i_psumAck (i_psumAck),
        .o_busy    (o_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // ======================================================================
    // random numbers and checks
    // ======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic checkPsum(input string sigName, input PECfg::tPsum expVal,
                             input PECfg::tPsum actVal);
        if (actVal !== expVal) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, sigName, expVal, actVal);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string sigName, input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, sigName, expVal, actVal);
            valueErrors++;
        end
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    task automatic buildRow(input tTestRow row);
        logic [31:0] rnd;
        int          acc;
        for (int ch = 0; ch < row.pch; ch++) begin
            for (int x = 0; x < row.tw + row.r - 1; x++) begin
                rnd = nextRand();
                pixMem[ch][x] = PECfg::tPixel'(rnd[7:0]);
            end
        end
        for (int m = 0; m < row.pm; m++) begin
            for (int ch = 0; ch < row.pch; ch++) begin
                for (int r = 0; r < row.r; r++) begin
                    rnd = nextRand();
                    wtMem[m][ch][r] = PECfg::tWeight'(rnd[7:0]);
                end
            end
        end
        expQ.delete();
        // results leave w outer, m inner
        for (int w = 0; w < row.tw; w++) begin
            for (int m = 0; m < row.pm; m++) begin
                acc = 0;
                for (int ch = 0; ch < row.pch; ch++) begin
                    for (int r = 0; r < row.r; r++) begin
                        acc += int'(pixMem[ch][w + r]) * int'(wtMem[m][ch][r]);
                    end
                end
                expQ.push_back(PECfg::tPsum'(acc));
            end
        end
    endtask

    // ======================================================================
    // stream drivers
    // ======================================================================
    // source keeps offering after the last word, so an ack past the count shows up
    task automatic feedPixels(input tTestRow row, input logic [31:0] seed);
        logic [31:0] rng;
        rng = seed;
        for (int ch = 0; ch < row.pch; ch++) begin
            for (int x = 0; x < row.tw + row.r - 1; x++) begin
                rng = xorshift32(rng);
                while (rng % 100 < row.srcGapPct) begin
                    i_inRdy <= 1'b0;
                    @(posedge i_clk);
                    rng = xorshift32(rng);
                end
                i_inRdy  <= 1'b1;
                i_inData <= pixMem[ch][x];
                do begin
                    @(posedge i_clk);
                end while (!o_inAck);
            end
        end
        wait (runDone);
        i_inRdy <= 1'b0;
    endtask

    task automatic feedWeights(input tTestRow row, input logic [31:0] seed);
        logic [31:0] rng;
        rng = seed;
        for (int m = 0; m < row.pm; m++) begin
            for (int ch = 0; ch < row.pch; ch++) begin
                for (int r = 0; r < row.r; r++) begin
                    rng = xorshift32(rng);
                    while (rng % 100 < row.srcGapPct) begin
                        i_wRdy <= 1'b0;
                        @(posedge i_clk);
                        rng = xorshift32(rng);
                    end
                    i_wRdy  <= 1'b1;
                    i_wData <= wtMem[m][ch][r];
                    do begin
                        @(posedge i_clk);
                    end while (!o_wAck);
                end
            end
        end
        wait (runDone);
        i_wRdy <= 1'b0;
    endtask

    task automatic collectPsums(input tTestRow row, input logic [31:0] seed);
        logic [31:0] rng;
        logic        rdySeen;
        logic        ackSeen;
        logic        busySeen;
        logic        holding;
        PECfg::tPsum dataSeen;
        PECfg::tPsum heldData;
        int          got;
        rng      = xorshift32(seed);
        holding  = 1'b0;
        heldData = '0;
        got      = 0;
        i_psumAck <= (rng % 100 >= row.ackGapPct);
        do begin
            @(posedge i_clk);
            rdySeen  = o_psumRdy;
            ackSeen  = i_psumAck;
            busySeen = o_busy;
            dataSeen = o_psumData;
            if (holding && !rdySeen) begin
                $display("at %0t: o_psumRdy dropped before its psum was taken", $time);
                protoErrors++;
            end else if (holding && dataSeen !== heldData) begin
                $display("at %0t: o_psumData changed while waiting for an ack", $time);
                protoErrors++;
            end
            if (rdySeen && ackSeen) begin
                if (got < expQ.size()) begin
                    checkPsum($sformatf("o_psumData[%0d]", got), expQ[got], dataSeen);
                    psumsChecked++;
                end
                got++;
                holding = 1'b0;
            end else begin
                holding  = rdySeen;
                heldData = dataSeen;
            end
            rng = xorshift32(rng);
            i_psumAck <= (rng % 100 >= row.ackGapPct);
        end while (busySeen || rdySeen);
        i_psumAck <= 1'b0;
        checkCount("o_psumRdy transfers", expQ.size(), got);
        runDone = 1'b1;
    endtask

    task automatic driveStalls(input tTestRow row, input logic [31:0] seed);
        logic [31:0] rng;
        rng = seed;
        while (!runDone) begin
            rng = xorshift32(rng);
            i_stall <= row.stallOn && (rng % 100 < 20);
            @(posedge i_clk);
        end
        i_stall <= 1'b0;
    endtask

    // ======================================================================
    // runs
    // ======================================================================
    task automatic applyConfig(input tTestRow row);
        i_confPch <= PECfg::tConfPch'(row.pch);
        i_confR   <= PECfg::tConfR'(row.r);
        i_confPm  <= PECfg::tConfPm'(row.pm);
        i_confTw  <= PECfg::tConfTw'(row.tw);
    endtask

    task automatic runRow(input int idx);
        tTestRow     row;
        logic [31:0] seeds [4];
        row = TEST_ROWS[idx];
        buildRow(row);
        for (int i = 0; i < 4; i++) begin
            seeds[i] = nextRand();
        end
        @(posedge i_clk);
        applyConfig(row);
        i_start <= 1'b1;
        inXfers = 0;
        wXfers  = 0;
        runDone = 1'b0;
        @(posedge i_clk);
        i_start <= 1'b0;
        fork
            feedPixels(row, seeds[0]);
            feedWeights(row, seeds[1]);
            collectPsums(row, seeds[2]);
            driveStalls(row, seeds[3]);
        join
        checkCount("o_inAck transfers", row.pch * (row.tw + row.r - 1), inXfers);
        checkCount("o_wAck transfers", row.pm * row.pch * row.r, wXfers);
    endtask

    // reset lands mid-run in LOAD or while a finished psum waits for its ack
    task automatic abortRun(input int idx, input bit psumPending);
        tTestRow row;
        row = TEST_ROWS[idx];
        @(posedge i_clk);
        applyConfig(row);
        i_start   <= 1'b1;
        i_inRdy   <= 1'b1;
        i_wRdy    <= 1'b1;
        i_inData  <= 8'sd5;
        i_wData   <= -8'sd3;
        i_psumAck <= 1'b0;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (psumPending) begin
            // no ack, so the first psum keeps o_psumRdy high
            do begin
                @(posedge i_clk);
            end while (!o_psumRdy);
        end else begin
            repeat (2) begin
                do begin
                    @(posedge i_clk);
                end while (!o_inAck);
            end
        end
        i_arstN <= 1'b0;
        @(negedge i_clk);
        if (o_busy || o_psumRdy || o_inAck || o_wAck) begin
            $display("at %0t: reset during a run left outputs high", $time);
            $display("  o_busy %b o_psumRdy %b o_inAck %b o_wAck %b",
                     o_busy, o_psumRdy, o_inAck, o_wAck);
            protoErrors++;
        end
        @(posedge i_clk);
        i_inRdy <= 1'b0;
        i_wRdy  <= 1'b0;
        @(posedge i_clk);
        i_arstN <= 1'b1;
    endtask

    // 4x the load and MAC cycles of each row, plus reset and the aborted runs
    function automatic int cycleBudget();
        int total;
        int loads;
        int macs;
        total = 64;
        for (int i = 0; i < NUM_ROWS; i++) begin
            loads = TEST_ROWS[i].pch * (TEST_ROWS[i].tw + TEST_ROWS[i].r - 1)
                  + TEST_ROWS[i].pm * TEST_ROWS[i].pch * TEST_ROWS[i].r;
            macs  = TEST_ROWS[i].pch * TEST_ROWS[i].r * TEST_ROWS[i].pm * TEST_ROWS[i].tw;
            total += (loads + macs + 20) * 4;
            if (i == ABORT_ROW) begin
                total += loads + macs;
            end
        end
        return total;
    endfunction

    // ======================================================================
    // monitors and timeout
    // ======================================================================
    always @(posedge i_clk) begin
        if (o_inAck && i_inRdy) begin
            inXfers++;
        end
        if (o_wAck && i_wRdy) begin
            wXfers++;
        end
    end

    always @(posedge i_clk) begin
        PECtlCfg::tRunState runState;
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            runState = dut0.ctl0.state;
            $display("timeout: run not finished after %0d cycles, controller in %s",
                     cycleLimit, runState.name());
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        i_arstN    = 1'b0;
        i_start    = 1'b0;
        i_stall    = 1'b0;
        i_confPch  = 3'd1;
        i_confR    = 3'd1;
        i_confPm   = 3'd1;
        i_confTw   = 4'd1;
        i_inRdy    = 1'b0;
        i_inData   = '0;
        i_wRdy     = 1'b0;
        i_wData    = '0;
        i_psumAck  = 1'b0;
        runDone    = 1'b0;
        rngState   = 32'd87;
        cycleLimit = cycleBudget();
        repeat (4) @(posedge i_clk);
        i_arstN <= 1'b1;
        for (int idx = 0; idx < NUM_ROWS; idx++) begin
            if (idx == ABORT_ROW) begin
                abortRun(idx, 1'b0);
                abortRun(idx, 1'b1);
            end
            runRow(idx);
        end
        repeat (2) @(posedge i_clk);
        $display("errors: %0d value, %0d protocol; %0d psums checked",
                 valueErrors, protoErrors, psumsChecked);
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
